// File: common/sound_pkg.sv
package sound_pkg;

   ////////////////////
   // Chip arrangement
   ////////////////////

   // Two generators in the turbo-sound pair
   localparam int NUM_CHIPS = 2;
   // Index width for the selected chip
   localparam int SEL_W = (NUM_CHIPS > 1) ? $clog2(NUM_CHIPS) : 1;
   // CPU data bus width
   localparam int DATA_W = 8;

   // Register file geometry
   localparam int REG_AW = 4;
   localparam int NUM_REGS = 2 ** REG_AW;

   // Tone channels per chip
   localparam int NUM_TONES = 3;
   localparam int PERIOD_W = 12;
   localparam int VOL_W = 4;
   localparam int CHIP_LEVEL_W = 8;

   // Mixer sum and DAC accumulator
   localparam int MIX_W = 10;

   // Tone tick divider
   localparam int TONE_PRESCALE = 8;
   localparam int PRESCALE_W = $clog2(TONE_PRESCALE);
   localparam int VOL_GAIN = 4;

   // Beeper contributions to the mix
   localparam logic [MIX_W-1:0] SPK_LEVEL = 10'd128;
   localparam logic [MIX_W-1:0] EAR_LEVEL = 10'd64;
   localparam logic [MIX_W-1:0] MIC_LEVEL = 10'd32;

   // Select code of chip 0, chip k answers to this minus k
   localparam logic [DATA_W-1:0] CHIP_SEL_TOP = 8'hFF;

   ////////////////////
   // Register map
   ////////////////////
   localparam logic [REG_AW-1:0] R_TONE_A_LO = 4'd0;
   localparam logic [REG_AW-1:0] R_TONE_A_HI = 4'd1;
   localparam logic [REG_AW-1:0] R_TONE_B_LO = 4'd2;
   localparam logic [REG_AW-1:0] R_TONE_B_HI = 4'd3;
   localparam logic [REG_AW-1:0] R_TONE_C_LO = 4'd4;
   localparam logic [REG_AW-1:0] R_TONE_C_HI = 4'd5;
   localparam logic [REG_AW-1:0] R_ENABLE = 4'd7;
   localparam logic [REG_AW-1:0] R_VOL_A = 4'd8;
   localparam logic [REG_AW-1:0] R_VOL_B = 4'd9;
   localparam logic [REG_AW-1:0] R_VOL_C = 4'd10;

   // CPU cycle classes seen at the sound ports
   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_ADDR_WR,
      BUS_DATA_WR,
      BUS_DATA_RD
   } bus_op_e;

endpackage

// File: sound/psg_bus_decoder.sv
`timescale 1ns/1ps

module psg_bus_decoder (
   input  logic                                               clk,
   input  logic                                               rst_n,
   // Raw CPU bus
   input  logic [15:0]                                        a,
   input  logic                                               iorq_n,
   input  logic                                               rd_n,
   input  logic                                               wr_n,
   input  logic [sound_pkg::DATA_W-1:0]                       din,
   // Read-back from every chip, chip k in slice k
   input  logic [sound_pkg::NUM_CHIPS*sound_pkg::DATA_W-1:0]  rd_data,
   // Shared register access to the chips
   output logic [sound_pkg::REG_AW-1:0]                       reg_addr,
   output logic [sound_pkg::DATA_W-1:0]                       wr_data,
   output logic [sound_pkg::NUM_CHIPS-1:0]                    wr_en,
   // CPU read path
   output logic [sound_pkg::DATA_W-1:0]                       dout,
   output logic                                               oe_n
);

   import sound_pkg::*;

   bus_op_e              bus_op;
   logic                 port_hit;
   logic                 sel_hit;
   logic [SEL_W-1:0]     sel_idx;
   logic [SEL_W-1:0]     chip_sel;

   ////////////////////
   // Cycle decode
   ////////////////////

   // Both sound ports have A15 high and A1..A0 = 01
   assign port_hit = !iorq_n && a[15] && (a[1:0] == 2'b01);

   always_comb begin
      bus_op = BUS_IDLE;
      if (port_hit && !wr_n) begin
         // A14 splits register select (FFFD) from data (BFFD)
         bus_op = a[14] ? BUS_ADDR_WR : BUS_DATA_WR;
      end else if (port_hit && !rd_n && a[14]) begin
         // Reads come back through the select port
         bus_op = BUS_DATA_RD;
      end
   end

   // Match din against the chip select codes
   always_comb begin
      sel_hit = 1'b0;
      sel_idx = '0;
      for (int k = 0; k < NUM_CHIPS; k++) begin
         if (din == CHIP_SEL_TOP - DATA_W'(k)) begin
            sel_hit = 1'b1;
            sel_idx = SEL_W'(k);
         end
      end
   end

   ////////////////////
   // Address and select latches
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_addr <= '0;
         chip_sel <= '0;
      end else if (bus_op == BUS_ADDR_WR) begin
         // Select code switches chip, address stays put
         if (sel_hit) begin
            chip_sel <= sel_idx;
         end else begin
            reg_addr <= din[REG_AW-1:0];
         end
      end
   end

   // Write strobe, one cycle after the bus cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_en <= '0;
      end else if (bus_op == BUS_DATA_WR) begin
         wr_en <= NUM_CHIPS'(1) << chip_sel;
      end else begin
         wr_en <= '0;
      end
   end

   // Write data travels alongside the strobe
   always_ff @(posedge clk) begin
      if (bus_op == BUS_DATA_WR) begin
         wr_data <= din;
      end
   end

   ////////////////////
   // Read-back
   ////////////////////
   assign dout = rd_data[chip_sel*DATA_W +: DATA_W];
   assign oe_n = (bus_op != BUS_DATA_RD);

endmodule

// File: sound/psg_chip.sv
`timescale 1ns/1ps

module psg_chip (
   input  logic                                 clk,
   input  logic                                 rst_n,
   // Register access from the bus decoder
   input  logic [sound_pkg::REG_AW-1:0]         reg_addr,
   input  logic [sound_pkg::DATA_W-1:0]         wr_data,
   input  logic                                 wr_en,
   output logic [sound_pkg::DATA_W-1:0]         rd_data,
   // Summed channel level to the mixer
   output logic [sound_pkg::CHIP_LEVEL_W-1:0]   level
);

   import sound_pkg::*;

   // Register file, all 16 entries kept in full
   logic [DATA_W-1:0]        regs [NUM_REGS];

   // Prescaler
   logic [PRESCALE_W-1:0]    presc;
   logic                     tick;

   // Per channel tone state
   logic [PERIOD_W-1:0]      period [NUM_TONES];
   logic [PERIOD_W-1:0]      period_eff [NUM_TONES];
   logic [PERIOD_W-1:0]      tone_cnt [NUM_TONES];
   logic [PERIOD_W:0]        cnt_inc [NUM_TONES];
   logic [NUM_TONES-1:0]     square;
   logic [NUM_TONES-1:0]     chan_on;
   logic [VOL_W-1:0]         vol [NUM_TONES];
   logic [CHIP_LEVEL_W-1:0]  contrib [NUM_TONES];
   logic [CHIP_LEVEL_W-1:0]  level_sum;

   ////////////////////
   // Register file
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] <= '0;
         end
      end else if (wr_en) begin
         regs[reg_addr] <= wr_data;
      end
   end

   // Read-back is straight from the array
   assign rd_data = regs[reg_addr];

   ////////////////////
   // Register fields
   ////////////////////
   always_comb begin
      // Fine byte plus low nibble of the coarse byte
      period[0] = {regs[R_TONE_A_HI][PERIOD_W-DATA_W-1:0], regs[R_TONE_A_LO]};
      period[1] = {regs[R_TONE_B_HI][PERIOD_W-DATA_W-1:0], regs[R_TONE_B_LO]};
      period[2] = {regs[R_TONE_C_HI][PERIOD_W-DATA_W-1:0], regs[R_TONE_C_LO]};
      vol[0] = regs[R_VOL_A][VOL_W-1:0];
      vol[1] = regs[R_VOL_B][VOL_W-1:0];
      vol[2] = regs[R_VOL_C][VOL_W-1:0];
   end

   ////////////////////
   // Tone prescaler
   ////////////////////
   assign tick = (presc == PRESCALE_W'(TONE_PRESCALE - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         presc <= '0;
      end else if (tick) begin
         presc <= '0;
      end else begin
         presc <= presc + 1'b1;
      end
   end

   ////////////////////
   // Tone channels
   ////////////////////
   always_comb begin
      for (int i = 0; i < NUM_TONES; i++) begin
         // Period 0 behaves like period 1
         period_eff[i] = (period[i] == '0) ? PERIOD_W'(1) : period[i];
         // One extra bit so the compare never wraps
         cnt_inc[i] = {1'b0, tone_cnt[i]} + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         square <= '0;
         for (int i = 0; i < NUM_TONES; i++) begin
            tone_cnt[i] <= '0;
         end
      end else if (tick) begin
         for (int i = 0; i < NUM_TONES; i++) begin
            // >= also catches a period lowered below the count
            if (cnt_inc[i] >= {1'b0, period_eff[i]}) begin
               tone_cnt[i] <= '0;
               square[i] <= ~square[i];
            end else begin
               tone_cnt[i] <= cnt_inc[i][PERIOD_W-1:0];
            end
         end
      end
   end

   ////////////////////
   // Channel levels
   ////////////////////
   always_comb begin
      level_sum = '0;
      for (int i = 0; i < NUM_TONES; i++) begin
         // Enable bit set means tone off, channel held high
         chan_on[i] = regs[R_ENABLE][i] | square[i];
         contrib[i] = chan_on[i] ? CHIP_LEVEL_W'(vol[i] * VOL_GAIN) : '0;
         level_sum = level_sum + contrib[i];
      end
   end

   // Max 3 x 60 = 180, fits in 8 bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         level <= '0;
      end else begin
         level <= level_sum;
      end
   end

endmodule

// File: sound/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
   input  logic                                                    clk,
   input  logic                                                    rst_n,
   // Chip levels, chip k in slice k
   input  logic [sound_pkg::NUM_CHIPS*sound_pkg::CHIP_LEVEL_W-1:0] level,
   // Beeper bits
   input  logic                                                    spk,
   input  logic                                                    mic,
   input  logic                                                    ear,
   // One-bit DAC output
   output logic                                                    audio_out
);

   import sound_pkg::*;

   logic [MIX_W-1:0]  sum_next;
   logic [MIX_W-1:0]  mix_sum;
   logic [MIX_W-1:0]  acc;

   ////////////////////
   // Level sum
   ////////////////////

   // Worst case 2 x 180 + 224 = 584, below 2^MIX_W
   always_comb begin
      sum_next = '0;
      for (int k = 0; k < NUM_CHIPS; k++) begin
         sum_next = sum_next + MIX_W'(level[k*CHIP_LEVEL_W +: CHIP_LEVEL_W]);
      end
      // Fixed beeper weights
      if (spk) begin
         sum_next = sum_next + SPK_LEVEL;
      end
      if (mic) begin
         sum_next = sum_next + MIC_LEVEL;
      end
      if (ear) begin
         sum_next = sum_next + EAR_LEVEL;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mix_sum <= '0;
      end else begin
         mix_sum <= sum_next;
      end
   end

   ////////////////////
   // Sigma-delta DAC
   ////////////////////

   // First order modulator
   // Carry out of the accumulator is the output bit
   // Density of ones is mix_sum / 2^MIX_W
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc <= '0;
         audio_out <= 1'b0;
      end else begin
         {audio_out, acc} <= {1'b0, acc} + {1'b0, mix_sum};
      end
   end

endmodule

// File: src/sound_top.sv
`timescale 1ns/1ps

module sound_top (
   input  logic                              clk,
   input  logic                              rst_n,
   // CPU bus
   input  logic [15:0]                       a,
   input  logic                              iorq_n,
   input  logic                              rd_n,
   input  logic                              wr_n,
   input  logic [sound_pkg::DATA_W-1:0]      din,
   output logic [sound_pkg::DATA_W-1:0]      dout,
   output logic                              oe_n,
   // Beeper sources
   input  logic                              spk,
   input  logic                              mic,
   input  logic                              ear,
   // One-bit audio
   output logic                              audio_out
);

   import sound_pkg::*;

   // Decoder to chips
   logic [REG_AW-1:0]                   reg_addr;
   logic [DATA_W-1:0]                   wr_data;
   logic [NUM_CHIPS-1:0]                wr_en;
   // Chips back to decoder and on to mixer
   logic [NUM_CHIPS*DATA_W-1:0]         rd_data;
   logic [NUM_CHIPS*CHIP_LEVEL_W-1:0]   level;

   psg_bus_decoder u_decoder (
      .clk      (clk),
      .rst_n    (rst_n),
      .a        (a),
      .iorq_n   (iorq_n),
      .rd_n     (rd_n),
      .wr_n     (wr_n),
      .din      (din),
      .rd_data  (rd_data),
      .reg_addr (reg_addr),
      .wr_data  (wr_data),
      .wr_en    (wr_en),
      .dout     (dout),
      .oe_n     (oe_n)
   );

   // One generator per select code
   for (genvar k = 0; k < NUM_CHIPS; k++) begin : g_chip
      psg_chip u_chip (
         .clk      (clk),
         .rst_n    (rst_n),
         .reg_addr (reg_addr),
         .wr_data  (wr_data),
         .wr_en    (wr_en[k]),
         .rd_data  (rd_data[k*DATA_W +: DATA_W]),
         .level    (level[k*CHIP_LEVEL_W +: CHIP_LEVEL_W])
      );
   end

   audio_mixer u_mixer (
      .clk       (clk),
      .rst_n     (rst_n),
      .level     (level),
      .spk       (spk),
      .mic       (mic),
      .ear       (ear),
      .audio_out (audio_out)
   );

endmodule

// File: sim/sound_assert.sv
`timescale 1ns/1ps

module sound_assert (
   input  logic         clk,
   input  logic         rst_n,
   input  logic [15:0]  a,
   input  logic         iorq_n,
   input  logic         rd_n,
   input  logic         wr_n,
   input  logic         oe_n,
   input  logic         audio_out
);

   // CPU read at the sound port, FFFD with A1..A0 = 01
   logic port_read;
   // Number of property failures so far
   int   fail_count = 0;

   assign port_read = !iorq_n && !rd_n && a[15] && a[14] && (a[1:0] == 2'b01);

   // Bus driver only opens for a real port read
   oe_only_on_read: assert property (@(posedge clk) disable iff (!rst_n)
      !oe_n |-> port_read)
      else begin
         $error("oe_n low without an I/O read at the sound port");
         fail_count++;
      end

   // DAC output must be a clean level
   audio_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(audio_out))
      else begin
         $error("audio_out unknown after reset");
         fail_count++;
      end

   // No bus contention during a CPU write
   oe_off_on_write: assert property (@(posedge clk) disable iff (!rst_n)
      !wr_n |-> oe_n)
      else begin
         $error("oe_n low while wr_n is low");
         fail_count++;
      end

endmodule

bind sound_top sound_assert u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .a         (a),
   .iorq_n    (iorq_n),
   .rd_n      (rd_n),
   .wr_n      (wr_n),
   .oe_n      (oe_n),
   .audio_out (audio_out)
);

// File: sim/sound_tb.sv
`timescale 1ns/1ps

module sound_tb;

   import sound_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam logic [15:0] PORT_SEL = 16'hFFFD;
   localparam logic [15:0] PORT_DATA = 16'hBFFD;
   localparam int NUM_RAND_WRITES = 200;
   localparam int SETTLE_CYCLES = 64;
   localparam int DAC_WINDOW = 1024;
   localparam int MAX_PERIOD = 63;
   // Cycle budget, longest tone window dominates
   localparam longint RUN_CYCLES = 300 + NUM_RAND_WRITES * 8 + 400 + 100
      + 2 * (300 + SETTLE_CYCLES) + DAC_WINDOW
      + DAC_WINDOW * 2 * MAX_PERIOD * TONE_PRESCALE;
   localparam longint WATCHDOG_NS = (RUN_CYCLES + 10000) * CLK_PERIOD;

   logic         clk;
   logic         rst_n;
   logic [15:0]  a;
   logic         iorq_n;
   logic         rd_n;
   logic         wr_n;
   logic [7:0]   din;
   logic [7:0]   dout;
   logic         oe_n;
   logic         spk;
   logic         mic;
   logic         ear;
   logic         audio_out;

   // Reference model of the register side
   logic [7:0]         model_regs [NUM_CHIPS][NUM_REGS];
   logic [REG_AW-1:0]  model_addr;
   int                 model_sel;
   logic [31:0]        rng_state;
   int                 value_errors;
   int                 other_errors;

   sound_top sound_top_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .iorq_n    (iorq_n),
      .rd_n      (rd_n),
      .wr_n      (wr_n),
      .din       (din),
      .dout      (dout),
      .oe_n      (oe_n),
      .spk       (spk),
      .mic       (mic),
      .ear       (ear),
      .audio_out (audio_out)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   // LCG, upper half only
   function automatic logic [15:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state[31:16];
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      assert (act_val === exp_val) else begin
         $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
         value_errors++;
      end
   endtask

   task automatic bus_idle();
      a = 16'h0000;
      din = 8'h00;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
   endtask

   // One-cycle write at FFFD, model follows the select rule
   task automatic addr_write(input logic [7:0] val);
      int k;
      logic hit;
      @(negedge clk);
      a = PORT_SEL;
      din = val;
      iorq_n = 1'b0;
      wr_n = 1'b0;
      @(negedge clk);
      bus_idle();
      hit = 1'b0;
      for (k = 0; k < NUM_CHIPS; k++) begin
         if (val == CHIP_SEL_TOP - 8'(k)) begin
            hit = 1'b1;
            model_sel = k;
         end
      end
      if (!hit) begin
         model_addr = val[REG_AW-1:0];
      end
   endtask

   task automatic data_write(input logic [7:0] val);
      @(negedge clk);
      a = PORT_DATA;
      din = val;
      iorq_n = 1'b0;
      wr_n = 1'b0;
      @(negedge clk);
      bus_idle();
      model_regs[model_sel][model_addr] = val;
   endtask

   // Read cycle, sampled mid low phase
   task automatic read_check(input logic [7:0] exp_val);
      @(negedge clk);
      a = PORT_SEL;
      iorq_n = 1'b0;
      rd_n = 1'b0;
      #(CLK_PERIOD / 4);
      check_value("oe_n", 32'h0, oe_n);
      check_value("dout", exp_val, dout);
      @(negedge clk);
      bus_idle();
   endtask

   task automatic check_idle();
      #(CLK_PERIOD / 4);
      check_value("oe_n", 32'h1, oe_n);
   endtask

   task automatic set_reg(input int chip, input logic [REG_AW-1:0] addr,
                          input logic [7:0] val);
      addr_write(CHIP_SEL_TOP - 8'(chip));
      addr_write(8'(addr));
      data_write(val);
   endtask

   task automatic count_high(input int cycles, output int ones);
      int n;
      ones = 0;
      for (n = 0; n < cycles; n++) begin
         @(negedge clk);
         if (audio_out) begin
            ones++;
         end
      end
   endtask

   ////////////////////
   // Watchdog
   ////////////////////
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish in the expected time");
      other_errors++;
      other_errors += sound_top_inst.u_assert.fail_count;
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      $display("Verification failed");
      $finish;
   end

   ////////////////////
   // Tests
   ////////////////////
   initial begin
      int i;
      int c;
      int ch;
      int ones;
      int expected;
      int tol;
      int period;
      int vol_total;
      logic [15:0] rnd;
      logic [7:0] d0;
      value_errors = 0;
      other_errors = 0;
      rng_state = 32'h5634_1496;
      rst_n = 1'b0;
      spk = 1'b0;
      mic = 1'b0;
      ear = 1'b0;
      bus_idle();
      for (c = 0; c < NUM_CHIPS; c++) begin
         for (i = 0; i < NUM_REGS; i++) begin
            model_regs[c][i] = 8'h00;
         end
      end
      model_addr = '0;
      model_sel = 0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      // Reset state, chip 0 all zero
      for (i = 0; i < NUM_REGS; i++) begin
         addr_write(8'(i));
         check_idle();
         read_check(8'h00);
      end

      // Random writes with select codes mixed in
      for (i = 0; i < NUM_RAND_WRITES; i++) begin
         rnd = next_rand();
         case (rnd[15:14])
            2'd0: addr_write(CHIP_SEL_TOP - 8'(rnd[8:0] % NUM_CHIPS));
            2'd1: addr_write(rnd[7:0]);
            default: ;
         endcase
         rnd = next_rand();
         data_write(rnd[11:4]);
         read_check(model_regs[model_sel][model_addr]);
      end
      // Sweep every register of both chips
      for (c = 0; c < NUM_CHIPS; c++) begin
         addr_write(CHIP_SEL_TOP - 8'(c));
         for (i = 0; i < NUM_REGS; i++) begin
            addr_write(8'(i));
            read_check(model_regs[c][i]);
         end
      end

      // Same register, different data per chip
      rnd = next_rand();
      d0 = rnd[15:8];
      // Differ from chip 0 register 15, where FF would point as an address
      if (d0 == model_regs[0][NUM_REGS-1]) begin
         d0 = ~d0;
      end
      addr_write(CHIP_SEL_TOP);
      // Address kept clear of the select code nibbles E and F
      addr_write({5'h00, rnd[2:0]});
      data_write(d0);
      // Select code must not move the address
      addr_write(CHIP_SEL_TOP - 8'd1);
      data_write(~d0);
      read_check(~d0);
      addr_write(CHIP_SEL_TOP);
      read_check(d0);
      addr_write(CHIP_SEL_TOP - 8'd1);
      read_check(~d0);

      // Constant level, tones off
      vol_total = 0;
      for (c = 0; c < NUM_CHIPS; c++) begin
         set_reg(c, R_ENABLE, 8'h07);
         for (ch = 0; ch < 3; ch++) begin
            rnd = next_rand();
            vol_total += rnd[15:12];
            set_reg(c, R_VOL_A + REG_AW'(ch), {4'h0, rnd[15:12]});
         end
      end
      rnd = next_rand();
      @(negedge clk);
      spk = rnd[15];
      mic = rnd[14];
      ear = rnd[13];
      expected = VOL_GAIN * vol_total + (spk ? int'(SPK_LEVEL) : 0)
         + (mic ? int'(MIC_LEVEL) : 0) + (ear ? int'(EAR_LEVEL) : 0);
      repeat (SETTLE_CYCLES) @(negedge clk);
      count_high(DAC_WINDOW, ones);
      assert ((ones >= expected - 1) && (ones <= expected + 1)) else begin
         $display("** Error: audio_out high count expected 0x%0h actual 0x%0h", expected, ones);
         value_errors++;
      end

      // Square wave on channel A of chip 0 only
      for (ch = 0; ch < 3; ch++) begin
         set_reg(1, R_VOL_A + REG_AW'(ch), 8'h00);
      end
      rnd = next_rand();
      period = 1 + (rnd % MAX_PERIOD);
      set_reg(0, R_TONE_A_LO, 8'(period));
      set_reg(0, R_TONE_A_HI, 8'h00);
      set_reg(0, R_VOL_A, 8'h0F);
      set_reg(0, R_VOL_B, 8'h00);
      set_reg(0, R_VOL_C, 8'h00);
      set_reg(0, R_ENABLE, 8'h06);
      @(negedge clk);
      spk = 1'b0;
      mic = 1'b0;
      ear = 1'b0;
      repeat (SETTLE_CYCLES) @(negedge clk);
      count_high(DAC_WINDOW * 2 * period * TONE_PRESCALE, ones);
      // Half duty at level 60
      expected = (15 * VOL_GAIN / 2) * 2 * period * TONE_PRESCALE;
      tol = expected / 50;
      assert ((ones >= expected - tol) && (ones <= expected + tol)) else begin
         $display("** Error: audio_out tone count expected 0x%0h actual 0x%0h", expected, ones);
         value_errors++;
      end

      // Bound protocol properties count as other failures
      other_errors += sound_top_inst.u_assert.fail_count;
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
common/sound_pkg.sv
sound/psg_bus_decoder.sv
sound/psg_chip.sv
sound/audio_mixer.sv
src/sound_top.sv
sim/sound_assert.sv
sim/sound_tb.sv
